/* testbench/jalr_trace.txt */
# D base_tag base_val imm pc pc_next dest exp_link exp_target exp_redirect
# W tag value, F (flush), N idle_cycles; all fields hex
D 0 00001000 00000010 00000100 00001010 1 00000104 00001010 0
D 0 00002001 00000004 00000200 00002004 2 00000204 00002004 0
D 0 00003000 fffffffc 00000300 00002ffc 3 00000304 00002ffc 0
D 5 00000000 00000008 00000400 00005008 4 00000404 00005008 0
N 6
W 5 00005000
D 0 00006000 00000000 00000500 00006000 6 00000504 00006000 0
D 6 00000000 00000020 00000600 00000524 7 00000604 00000524 0
D 8 00000000 00000000 00000700 00009000 9 00000704 00009000 0
D 8 00000000 00000004 00000800 00009004 a 00000804 00009004 0
N 4
W 8 00009000
N 8
D 0 00007000 00000000 00000900 00007004 b 00000904 00007000 1
D 0 00007100 00000000 00000a00 00007100 c 00000a04 00007100 0
N 6
D e 00000000 00000000 00000b00 00000000 d 00000b04 00000000 0
N 6
F
N 8
D f 00000000 00000000 00000c00 00000100 1 00000c04 00000100 0
D f 00000000 00000004 00000d00 00000104 2 00000d04 00000104 0
N 5
W f 00000100
D 0 00000003 00000008 00000e00 0000000a 3 00000e04 0000000a 0
N 10

/* sources.f */
design/rv32i_pkg.sv
design/ooo_pkg.sv
design/jalr_dispatch_if.sv
design/operand_tracker.sv
design/dispatch_gate.sv
design/jalr_station.sv
design/jalr_top.sv
testbench/jalr_asserts.sv
testbench/jalr_checker.sv
testbench/jalr_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module jalr_tb -f sources.f -o jalr_sim
out=$(./obj_dir/jalr_sim)
echo "$out"
if echo "$out" | grep -qx "ALL TESTS PASSED"; then
    exit 0
else
    exit 1
fi

/* testbench/jalr_tb.sv */
module jalr_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int READY_TIMEOUT = 50;
    localparam int DRAIN_TIMEOUT = 200;

    logic        clk;
    logic        rst_n;
    logic        flush;
    logic        disp_valid;
    logic        disp_ready;
    logic [3:0]  disp_base_tag;
    logic [3:0]  disp_dest;
    logic [31:0] disp_base_val;
    logic [31:0] disp_imm;
    logic [31:0] disp_pc;
    logic [31:0] disp_pc_next;
    logic        wb_valid;
    logic [3:0]  wb_tag;
    logic [31:0] wb_val;
    logic        cdb_valid;
    logic [3:0]  cdb_tag;
    logic [31:0] cdb_val;
    logic        redirect_valid;
    logic [31:0] redirect_pc;
    logic [31:0] exp_link;
    logic [31:0] exp_target;
    logic        exp_redirect;
    int          open_count;
    int          test_count;
    int          error_count;
    logic        aborted;

    jalr_top jalr_top_inst (.*);

    jalr_checker checker_inst (.*);

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // trace commands
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic dispatch_jump(input logic [31:0] tag, bval, imm, pc, pnext, dest,
                                 input logic [31:0] elink, etarget, eredir);
        int waited;
        @(posedge clk);
        disp_valid    <= 1'b1;
        disp_base_tag <= tag[3:0];
        disp_base_val <= bval;
        disp_imm      <= imm;
        disp_pc       <= pc;
        disp_pc_next  <= pnext;
        disp_dest     <= dest[3:0];
        exp_link      <= elink;
        exp_target    <= etarget;
        exp_redirect  <= eredir[0];
        waited = 0;
        @(negedge clk);
        while (!disp_ready && waited < READY_TIMEOUT) begin
            waited++;
            @(negedge clk);
        end
        if (!disp_ready) begin
            $display("dispatch of pc %h stalled, disp_ready low for %0d cycles", pc, waited);
            aborted = 1'b1;
        end
        @(posedge clk);
        disp_valid <= 1'b0;
    endtask

    task automatic write_back(input logic [31:0] tag, val);
        @(posedge clk);
        wb_valid <= 1'b1;
        wb_tag   <= tag[3:0];
        wb_val   <= val;
        @(posedge clk);
        wb_valid <= 1'b0;
    endtask

    task automatic flush_station();
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
    endtask

    task automatic run_trace();
        int          fd;
        int          code;
        int          gap;
        string       line;
        logic [7:0]  cmd;
        logic [31:0] a0, a1, a2, a3, a4, a5, a6, a7, a8;
        fd = $fopen("testbench/jalr_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open the trace file");
            aborted = 1'b1;
        end else begin
            while (!aborted && !$feof(fd)) begin
                code = $fgets(line, fd);
                if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
                    code = $sscanf(line, "%c %h %h %h %h %h %h %h %h %h",
                                   cmd, a0, a1, a2, a3, a4, a5, a6, a7, a8);
                    case (cmd)
                        "D": dispatch_jump(a0, a1, a2, a3, a4, a5, a6, a7, a8);
                        "W": write_back(a0, a1);
                        "F": flush_station();
                        "N": repeat (a0) @(posedge clk);
                        default: begin
                            $display("unknown trace command in line: %s", line);
                            aborted = 1'b1;
                        end
                    endcase
                    gap = $urandom_range(2, 0);
                    repeat (gap) @(posedge clk);
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        int seed;
        int waited;
        seed = $urandom(32694);
        aborted       = 1'b0;
        rst_n         <= 1'b0;
        flush         <= 1'b0;
        disp_valid    <= 1'b0;
        disp_base_tag <= '0;
        disp_base_val <= '0;
        disp_imm      <= '0;
        disp_pc       <= '0;
        disp_pc_next  <= '0;
        disp_dest     <= '0;
        wb_valid      <= 1'b0;
        wb_tag        <= '0;
        wb_val        <= '0;
        exp_link      <= '0;
        exp_target    <= '0;
        exp_redirect  <= 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        run_trace();
        waited = 0;
        while (open_count != 0 && waited < DRAIN_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (open_count != 0) begin
            $display("%0d jumps still have no result after the trace", open_count);
            aborted = 1'b1;
        end
        repeat (2) @(negedge clk);
        $display("tests: %0d, errors: %0d", test_count, error_count);
        if (!aborted && error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* testbench/jalr_checker.sv */
module jalr_checker (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 flush,
    input  logic                 disp_valid,
    input  logic                 disp_ready,
    input  logic [3:0]           disp_base_tag,
    input  rv32i_pkg::rv32i_word disp_base_val,
    input  rv32i_pkg::rv32i_word disp_imm,
    input  rv32i_pkg::rv32i_word disp_pc,
    input  rv32i_pkg::rv32i_word disp_pc_next,
    input  logic [3:0]           disp_dest,
    input  logic                 wb_valid,
    input  logic [3:0]           wb_tag,
    input  rv32i_pkg::rv32i_word wb_val,
    input  logic                 cdb_valid,
    input  logic [3:0]           cdb_tag,
    input  rv32i_pkg::rv32i_word cdb_val,
    input  logic                 redirect_valid,
    input  rv32i_pkg::rv32i_word redirect_pc,
    input  rv32i_pkg::rv32i_word exp_link,
    input  rv32i_pkg::rv32i_word exp_target,
    input  logic                 exp_redirect,
    output int                   open_count,
    output int                   test_count,
    output int                   error_count
);
    timeunit 1ns;
    timeprecision 1ps;
    import rv32i_pkg::*;

    localparam int MAX_JUMPS      = 32;
    localparam int RESULT_TIMEOUT = 100;

    logic       is_open [MAX_JUMPS];
    int         age     [MAX_JUMPS];
    logic [3:0] j_tag   [MAX_JUMPS];
    logic [3:0] j_dest  [MAX_JUMPS];
    rv32i_word  j_bval  [MAX_JUMPS];
    rv32i_word  j_imm   [MAX_JUMPS];
    rv32i_word  j_pc    [MAX_JUMPS];
    rv32i_word  j_pnext [MAX_JUMPS];
    rv32i_word  j_link  [MAX_JUMPS];
    rv32i_word  j_targ  [MAX_JUMPS];
    logic       j_redir [MAX_JUMPS];
    rv32i_word  tag_val [16];
    logic       tag_rdy [16];
    int         n_jumps;
    int         credits;
    logic       freed;

    task automatic check_result();
        int        k;
        int        bad;
        rv32i_word base;
        rv32i_word link;
        rv32i_word target;
        logic      mis;
        k = -1;
        for (int i = MAX_JUMPS - 1; i >= 0; i--) begin
            if (is_open[i] && j_dest[i] == cdb_tag) begin
                k = i;
            end
        end
        if (k < 0) begin
            $display("result at %0t with tag %0d matches no outstanding jump", $time, cdb_tag);
            error_count++;
        end else begin
            bad    = 0;
            base   = (j_tag[k] == 4'd0) ? j_bval[k] : tag_val[j_tag[k]];
            link   = j_pc[k] + 32'd4;
            target = (base + j_imm[k]) & ~32'h1;
            mis    = (target != j_pnext[k]);
            if (j_tag[k] != 4'd0 && !tag_rdy[j_tag[k]]) begin
                $display("result for dest %0d came before its base was written", j_dest[k]);
                bad++;
            end
            if (cdb_val !== link) begin
                $display("ERROR %0t cdb_val expected %h got %h", $time, link, cdb_val);
                bad++;
            end
            if (redirect_valid !== mis) begin
                $display("ERROR %0t redirect_valid expected %0b got %0b", $time, mis,
                         redirect_valid);
                bad++;
            end else if (mis && redirect_pc !== target) begin
                $display("ERROR %0t redirect_pc expected %h got %h", $time, target, redirect_pc);
                bad++;
            end
            for (int j = 0; j < k; j++) begin
                if (is_open[j] && j_tag[j] == j_tag[k]) begin
                    $display("dest %0d issued ahead of older dest %0d", j_dest[k], j_dest[j]);
                    bad++;
                end
            end
            if (j_link[k] != link || j_targ[k] != target || j_redir[k] != mis) begin
                $display("trace values for dest %0d disagree with the jump rules", j_dest[k]);
                bad++;
            end
            is_open[k] = 1'b0;
            tag_val[j_dest[k]] = link;
            tag_rdy[j_dest[k]] = 1'b1;
            freed = !mis;
            open_count--;
            test_count++;
            error_count += bad;
            $display("test %0d (dest %0d): %s", k, j_dest[k], (bad == 0) ? "pass" : "FAIL");
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < MAX_JUMPS; i++) begin
                is_open[i] = 1'b0;
            end
            for (int i = 0; i < 16; i++) begin
                tag_rdy[i] = 1'b0;
            end
            n_jumps     = 0;
            credits     = ooo_pkg::JALR_ENTRIES;
            open_count  = 0;
            test_count  = 0;
            error_count = 0;
        end else begin
            if (disp_ready !== (credits != 0)) begin
                $display("ERROR %0t disp_ready expected %0b got %0b", $time, credits != 0,
                         disp_ready);
                error_count++;
            end
            freed = 1'b0;
            if (cdb_valid) begin
                check_result();
            end
            for (int i = 0; i < MAX_JUMPS; i++) begin
                if (is_open[i]) begin
                    age[i]++;
                    if (flush) begin
                        // a flushed jump never reports.
                        is_open[i] = 1'b0;
                        open_count--;
                    end else if (age[i] > RESULT_TIMEOUT) begin
                        $display("test %0d (dest %0d): FAIL, no result within %0d cycles",
                                 i, j_dest[i], RESULT_TIMEOUT);
                        is_open[i] = 1'b0;
                        open_count--;
                        test_count++;
                        error_count++;
                    end
                end
            end
            if (flush) begin
                credits = ooo_pkg::JALR_ENTRIES;
            end else begin
                credits = credits - int'(disp_valid && disp_ready) + int'(freed);
            end
            if (wb_valid) begin
                tag_val[wb_tag] = wb_val;
                tag_rdy[wb_tag] = 1'b1;
            end
            if (disp_valid && disp_ready && !flush && n_jumps < MAX_JUMPS) begin
                is_open[n_jumps] = 1'b1;
                age[n_jumps]     = 0;
                j_tag[n_jumps]   = disp_base_tag;
                j_dest[n_jumps]  = disp_dest;
                j_bval[n_jumps]  = disp_base_val;
                j_imm[n_jumps]   = disp_imm;
                j_pc[n_jumps]    = disp_pc;
                j_pnext[n_jumps] = disp_pc_next;
                j_link[n_jumps]  = exp_link;
                j_targ[n_jumps]  = exp_target;
                j_redir[n_jumps] = exp_redirect;
                tag_rdy[disp_dest] = 1'b0;
                n_jumps++;
                open_count++;
            end
        end
    end

endmodule

/* testbench/jalr_asserts.sv */
module jalr_asserts (
    input logic                             clk,
    input logic                             rst_n,
    input logic                             flush,
    input logic                             cdb_valid,
    input logic                             redirect_valid,
    input logic [ooo_pkg::JALR_ENTRIES-1:0] busy,
    input logic [ooo_pkg::JALR_ENTRIES-1:0] done
);
    timeunit 1ns;
    timeprecision 1ps;

    // slots that issued with a wrong prediction and now wait for flush.
    logic [ooo_pkg::JALR_ENTRIES-1:0] held;

    assign held = busy & done;

    flags_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown({cdb_valid, redirect_valid}))
        else $error("cdb_valid or redirect_valid is unknown");

    redirect_has_result: assert property (@(posedge clk) disable iff (!rst_n)
        redirect_valid |-> cdb_valid)
        else $error("redirect_valid without cdb_valid");

    held_until_flush: assert property (@(posedge clk) disable iff (!rst_n)
        (held != '0) && !flush |=> (held & $past(held)) == $past(held))
        else $error("mispredicted slot released before flush");

endmodule

bind jalr_station jalr_asserts jalr_asserts_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .flush          (flush),
    .cdb_valid      (cdb_valid),
    .redirect_valid (redirect_valid),
    .busy           (busy),
    .done           (done)
);

/* design/jalr_top.sv */
module jalr_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 flush,
    input  logic                 disp_valid,
    input  rv32i_pkg::rv32i_word disp_base_val,
    input  ooo_pkg::tag_t        disp_base_tag,
    input  rv32i_pkg::rv32i_word disp_imm,
    input  rv32i_pkg::rv32i_addr disp_pc,
    input  rv32i_pkg::rv32i_addr disp_pc_next,
    input  ooo_pkg::tag_t        disp_dest,
    output logic                 disp_ready,
    input  logic                 wb_valid,
    input  ooo_pkg::tag_t        wb_tag,
    input  rv32i_pkg::rv32i_word wb_val,
    output logic                 cdb_valid,
    output ooo_pkg::tag_t        cdb_tag,
    output rv32i_pkg::rv32i_word cdb_val,
    output logic                 redirect_valid,
    output rv32i_pkg::rv32i_addr redirect_pc
);
    import ooo_pkg::*;
    import rv32i_pkg::*;

    tag_t [JALR_ENTRIES-1:0] stn_query_tag;
    tag_t                    gate_lookup_tag;
    logic [JALR_ENTRIES:0]   trk_ready;
    rv32i_word [JALR_ENTRIES:0] trk_val;

    jalr_dispatch_if dispatch_if ();

    // the last lookup port belongs to the gate, the rest to the station slots.
    operand_tracker operand_tracker_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .wb_valid    (wb_valid),
        .wb_tag      (wb_tag),
        .wb_val      (wb_val),
        .res_valid   (cdb_valid),
        .res_tag     (cdb_tag),
        .res_val     (cdb_val),
        .alloc_valid (dispatch_if.valid),
        .alloc_tag   (dispatch_if.dest),
        .query_tag   ({gate_lookup_tag, stn_query_tag}),
        .query_ready (trk_ready),
        .query_val   (trk_val)
    );

    dispatch_gate dispatch_gate_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush         (flush),
        .disp_valid    (disp_valid),
        .disp_base_val (disp_base_val),
        .disp_base_tag (disp_base_tag),
        .disp_imm      (disp_imm),
        .disp_pc       (disp_pc),
        .disp_pc_next  (disp_pc_next),
        .disp_dest     (disp_dest),
        .lookup_ready  (trk_ready[JALR_ENTRIES]),
        .lookup_val    (trk_val[JALR_ENTRIES]),
        .disp_ready    (disp_ready),
        .lookup_tag    (gate_lookup_tag),
        .link          (dispatch_if.gate)
    );

    jalr_station jalr_station_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .flush          (flush),
        .link           (dispatch_if.station),
        .query_tag      (stn_query_tag),
        .query_ready    (trk_ready[JALR_ENTRIES-1:0]),
        .query_val      (trk_val[JALR_ENTRIES-1:0]),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .cdb_val        (cdb_val),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

endmodule

/* design/jalr_station.sv */
module jalr_station (
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  logic                                         flush,
    jalr_dispatch_if.station                             link,
    output ooo_pkg::tag_t [ooo_pkg::JALR_ENTRIES-1:0]    query_tag,
    input  logic [ooo_pkg::JALR_ENTRIES-1:0]             query_ready,
    input  rv32i_pkg::rv32i_word [ooo_pkg::JALR_ENTRIES-1:0] query_val,
    output logic                                         cdb_valid,
    output ooo_pkg::tag_t                                cdb_tag,
    output rv32i_pkg::rv32i_word                         cdb_val,
    output logic                                         redirect_valid,
    output rv32i_pkg::rv32i_addr                         redirect_pc
);
    import ooo_pkg::*;
    import rv32i_pkg::*;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // slot storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic [JALR_ENTRIES-1:0] busy;
    // set once a slot has issued with a wrong prediction.
    logic [JALR_ENTRIES-1:0] done;
    // set when the slot is older than the other occupied slot.
    logic [JALR_ENTRIES-1:0] age;
    rv32i_word               base_val [JALR_ENTRIES];
    tag_t                    base_tag [JALR_ENTRIES];
    rv32i_word               imm      [JALR_ENTRIES];
    rv32i_addr               pc       [JALR_ENTRIES];
    rv32i_addr               pc_next  [JALR_ENTRIES];
    tag_t                    dest     [JALR_ENTRIES];

    slot_idx_t free_idx;
    slot_idx_t sel;
    logic      found;
    rv32i_addr target;
    logic      mispredict;

    always_comb begin
        for (int i = 0; i < JALR_ENTRIES; i++) begin
            query_tag[i] = base_tag[i];
        end
    end

    // credits guarantee a free slot whenever link.valid is high.
    always_comb begin
        free_idx = '0;
        for (int i = JALR_ENTRIES - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                free_idx = slot_idx_t'(i);
            end
        end
    end

    // oldest ready slot wins.
    always_comb begin
        found = 1'b0;
        sel   = '0;
        for (int i = 0; i < JALR_ENTRIES; i++) begin
            if (busy[i] && !done[i] && base_tag[i] == '0 && (!found || age[i])) begin
                found = 1'b1;
                sel   = slot_idx_t'(i);
            end
        end
    end

    assign target     = (base_val[sel] + imm[sel]) & ~rv32i_addr'(1);
    assign mispredict = (target != pc_next[sel]);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // control and issue
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy           <= '0;
            done           <= '0;
            age            <= '0;
            cdb_valid      <= 1'b0;
            redirect_valid <= 1'b0;
            link.credit    <= 1'b0;
        end else if (flush) begin
            busy           <= '0;
            done           <= '0;
            age            <= '0;
            cdb_valid      <= 1'b0;
            redirect_valid <= 1'b0;
            link.credit    <= 1'b0;
        end else begin
            cdb_valid      <= found;
            redirect_valid <= found && mispredict;
            link.credit    <= found && !mispredict;
            if (found) begin
                if (mispredict) begin
                    done[sel] <= 1'b1;
                end else begin
                    busy[sel] <= 1'b0;
                end
            end
            if (link.valid) begin
                busy[free_idx] <= 1'b1;
                done[free_idx] <= 1'b0;
                for (int i = 0; i < JALR_ENTRIES; i++) begin
                    age[i] <= (slot_idx_t'(i) != free_idx);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (found) begin
            cdb_tag     <= dest[sel];
            cdb_val     <= pc[sel] + rv32i_word'(INSN_BYTES);
            redirect_pc <= target;
        end
    end

    // a waiting slot picks up its base once the tracker reports it.
    always_ff @(posedge clk) begin
        for (int i = 0; i < JALR_ENTRIES; i++) begin
            if (link.valid && free_idx == slot_idx_t'(i)) begin
                base_val[i] <= link.base_val;
                base_tag[i] <= link.base_tag;
                imm[i]      <= link.imm;
                pc[i]       <= link.pc;
                pc_next[i]  <= link.pc_next;
                dest[i]     <= link.dest;
            end else if (busy[i] && base_tag[i] != '0 && query_ready[i]) begin
                base_val[i] <= query_val[i];
                base_tag[i] <= '0;
            end
        end
    end

endmodule

/* design/dispatch_gate.sv */
module dispatch_gate (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 flush,
    input  logic                 disp_valid,
    input  rv32i_pkg::rv32i_word disp_base_val,
    input  ooo_pkg::tag_t        disp_base_tag,
    input  rv32i_pkg::rv32i_word disp_imm,
    input  rv32i_pkg::rv32i_addr disp_pc,
    input  rv32i_pkg::rv32i_addr disp_pc_next,
    input  ooo_pkg::tag_t        disp_dest,
    input  logic                 lookup_ready,
    input  rv32i_pkg::rv32i_word lookup_val,
    output logic                 disp_ready,
    output ooo_pkg::tag_t        lookup_tag,
    jalr_dispatch_if.gate        link
);
    import ooo_pkg::*;

    credit_t credits;
    logic    send;

    assign disp_ready = (credits != '0);
    assign send       = disp_valid && disp_ready && !flush;
    assign lookup_tag = disp_base_tag;

    // one credit per station slot; flush hands every slot back.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits <= credit_t'(JALR_ENTRIES);
        end else if (flush) begin
            credits <= credit_t'(JALR_ENTRIES);
        end else begin
            credits <= credits - credit_t'(send) + credit_t'(link.credit);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            link.valid <= 1'b0;
        end else begin
            link.valid <= send;
        end
    end

    // a base tag that is already ready travels as its value with tag 0.
    always_ff @(posedge clk) begin
        if (send) begin
            if (lookup_ready) begin
                link.base_tag <= '0;
                link.base_val <= (disp_base_tag == '0) ? disp_base_val : lookup_val;
            end else begin
                link.base_tag <= disp_base_tag;
                link.base_val <= disp_base_val;
            end
            link.imm     <= disp_imm;
            link.pc      <= disp_pc;
            link.pc_next <= disp_pc_next;
            link.dest    <= disp_dest;
        end
    end

endmodule

/* design/operand_tracker.sv */
module operand_tracker (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        wb_valid,
    input  ooo_pkg::tag_t                               wb_tag,
    input  rv32i_pkg::rv32i_word                        wb_val,
    input  logic                                        res_valid,
    input  ooo_pkg::tag_t                               res_tag,
    input  rv32i_pkg::rv32i_word                        res_val,
    input  logic                                        alloc_valid,
    input  ooo_pkg::tag_t                               alloc_tag,
    input  ooo_pkg::tag_t [ooo_pkg::JALR_ENTRIES:0]     query_tag,
    output logic [ooo_pkg::JALR_ENTRIES:0]              query_ready,
    output rv32i_pkg::rv32i_word [ooo_pkg::JALR_ENTRIES:0] query_val
);
    import ooo_pkg::*;
    import rv32i_pkg::*;

    logic [ROB_DEPTH-1:0] ready;
    rv32i_word            vals [ROB_DEPTH];

    // a freshly allocated tag goes pending; a later write in the same cycle wins.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ready <= '0;
        end else begin
            if (alloc_valid) begin
                ready[alloc_tag] <= 1'b0;
            end
            if (res_valid) begin
                ready[res_tag] <= 1'b1;
            end
            if (wb_valid) begin
                ready[wb_tag] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (res_valid) begin
            vals[res_tag] <= res_val;
        end
        if (wb_valid) begin
            vals[wb_tag] <= wb_val;
        end
    end

    // lookups see writes of the current cycle, and a pending allocation
    // hides the stale ready bit of the tag's previous owner.
    always_comb begin
        for (int i = 0; i <= JALR_ENTRIES; i++) begin
            query_ready[i] = ready[query_tag[i]];
            query_val[i]   = vals[query_tag[i]];
            if (wb_valid && wb_tag == query_tag[i]) begin
                query_ready[i] = 1'b1;
                query_val[i]   = wb_val;
            end else if (res_valid && res_tag == query_tag[i]) begin
                query_ready[i] = 1'b1;
                query_val[i]   = res_val;
            end else if (alloc_valid && alloc_tag == query_tag[i]) begin
                query_ready[i] = 1'b0;
            end
            if (query_tag[i] == '0) begin
                query_ready[i] = 1'b1;
            end
        end
    end

endmodule

/* design/jalr_dispatch_if.sv */
interface jalr_dispatch_if;
    import ooo_pkg::*;
    import rv32i_pkg::*;

    logic      valid;
    rv32i_word base_val;
    tag_t      base_tag;
    rv32i_word imm;
    rv32i_addr pc;
    rv32i_addr pc_next;
    tag_t      dest;
    // one pulse per freed station slot.
    logic      credit;

    modport gate (
        output valid, base_val, base_tag, imm, pc, pc_next, dest,
        input  credit
    );

    modport station (
        input  valid, base_val, base_tag, imm, pc, pc_next, dest,
        output credit
    );

endinterface

/* design/ooo_pkg.sv */
package ooo_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reorder buffer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int ROB_DEPTH = 16;
    localparam int TAG_W     = $clog2(ROB_DEPTH);

    // tag 0 is never handed out; it marks an operand whose value is present.
    typedef logic [TAG_W-1:0] tag_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // JALR reservation station
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int JALR_ENTRIES = 2;
    localparam int CREDIT_W     = $clog2(JALR_ENTRIES + 1);
    localparam int SLOT_W       = $clog2(JALR_ENTRIES);

    // must be able to hold the full count of JALR_ENTRIES.
    typedef logic [CREDIT_W-1:0] credit_t;

    // index of one station slot.
    typedef logic [SLOT_W-1:0] slot_idx_t;

endpackage

/* design/rv32i_pkg.sv */
package rv32i_pkg;

    // architectural width of the base integer ISA.
    localparam int XLEN = 32;

    // size of one instruction in bytes; the link value is pc plus this.
    localparam int INSN_BYTES = 4;

    // a data word as held in a register or produced by a unit.
    typedef logic [XLEN-1:0] rv32i_word;

    // an instruction address.
    typedef logic [XLEN-1:0] rv32i_addr;

endpackage
